// File: sources.f
+incdir+include
src/uart_mon_pkg.sv
src/uart_char_decoder.sv
src/hex_word_collector.sv
src/monitor_cmd_fsm.sv
src/monitor_ctrl_out.sv
src/uart_monitor_top.sv
verif/uart_monitor_tb.sv

// File: src/hex_word_collector.sv
// hex word collector that builds 32-bit words from eight hex digits
`timescale 1ns/1ps

module hex_word_collector (
	input  logic                     clk,
	input  logic                     rst_n,
	input  uart_mon_pkg::char_info_t char_info,
	input  logic                     collect,
	input  logic                     word_clear,
	output uart_mon_pkg::mon_word_t  word
);

	logic [uart_mon_pkg::word_w-1:0]                  work_word;
	logic [uart_mon_pkg::word_w-1:0]                  shifted;
	logic [$clog2(uart_mon_pkg::digits_per_word)-1:0] digit_cnt;
	logic                                             take;
	logic                                             last_digit;

	// only hex chars while a number is expected
	assign take       = char_info.valid & char_info.is_hex & collect;
	assign last_digit = take & (int'(digit_cnt) == uart_mon_pkg::digits_per_word - 1);
	assign shifted    = {work_word[uart_mon_pkg::word_w-uart_mon_pkg::nibble_w-1:0],
		char_info.nibble};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			work_word <= '0;
			digit_cnt <= '0;
		end else if (word_clear) begin
			work_word <= '0;
			digit_cnt <= '0;
		end else if (take) begin
			work_word <= shifted; // new digit in at the low end
			if (last_digit)
				digit_cnt <= '0;
			else
				digit_cnt <= digit_cnt + 1'b1;
		end
	end

	// completed word holds until the next one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word <= '0;
		end else begin
			word.valid <= last_digit;
			if (last_digit)
				word.data <= shifted;
		end
	end

endmodule

// File: src/monitor_cmd_fsm.sv
// monitor command FSM that steps through command arguments and aborts
`timescale 1ns/1ps

module monitor_cmd_fsm (
	input  logic                     clk,
	input  logic                     rst_n,
	input  uart_mon_pkg::char_info_t char_info,
	input  uart_mon_pkg::mon_word_t  word,
	input  logic                     dump_running,
	input  logic                     bp_hit,
	output uart_mon_pkg::mon_state_e state,
	output logic                     collect,
	output logic                     word_clear,
	output logic                     abort,
	output logic                     go_launch,
	output logic                     crlf_in
);

	uart_mon_pkg::mon_state_e state_next;
	logic                     cr_c;
	logic                     arg_done; // address word that ends with a crlf

	assign abort = char_info.valid & (char_info.cmd == uart_mon_pkg::cmd_quit);
	assign cr_c  = char_info.valid & (char_info.cmd == uart_mon_pkg::cmd_cr);

	always_comb begin
		state_next = state;
		case (state)
			uart_mon_pkg::st_idle:
				if (char_info.valid) begin
					case (char_info.cmd)
						uart_mon_pkg::cmd_go:       state_next = uart_mon_pkg::st_go_addr;
						uart_mon_pkg::cmd_write:    state_next = uart_mon_pkg::st_wr_addr;
						uart_mon_pkg::cmd_read:     state_next = uart_mon_pkg::st_rd_start;
						uart_mon_pkg::cmd_stop_set: state_next = uart_mon_pkg::st_bp_addr;
						default:                    state_next = uart_mon_pkg::st_idle;
					endcase
				end
			uart_mon_pkg::st_go_addr:
				if (word.valid)
					state_next = uart_mon_pkg::st_go_run;
			uart_mon_pkg::st_go_run:
				if (bp_hit)
					state_next = uart_mon_pkg::st_idle; // break point reached
			uart_mon_pkg::st_wr_addr:
				if (word.valid)
					state_next = uart_mon_pkg::st_wr_data;
			uart_mon_pkg::st_wr_data:
				state_next = uart_mon_pkg::st_wr_data; // data words until Ctrl-c
			uart_mon_pkg::st_rd_start:
				if (word.valid)
					state_next = uart_mon_pkg::st_rd_end;
			uart_mon_pkg::st_rd_end:
				if (word.valid)
					state_next = uart_mon_pkg::st_rd_dump;
			uart_mon_pkg::st_rd_dump:
				if (!dump_running)
					state_next = uart_mon_pkg::st_idle;
			uart_mon_pkg::st_bp_addr:
				if (word.valid)
					state_next = uart_mon_pkg::st_idle;
			default:
				state_next = uart_mon_pkg::st_idle;
		endcase
		if (abort)
			state_next = uart_mon_pkg::st_idle; // Ctrl-c wins everywhere
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= uart_mon_pkg::st_idle;
		else
			state <= state_next;
	end

	assign collect = (state == uart_mon_pkg::st_go_addr) | (state == uart_mon_pkg::st_wr_addr)
		| (state == uart_mon_pkg::st_wr_data) | (state == uart_mon_pkg::st_rd_start)
		| (state == uart_mon_pkg::st_rd_end) | (state == uart_mon_pkg::st_bp_addr);

	// entering a number state from idle starts a fresh word
	assign word_clear = ((state == uart_mon_pkg::st_idle) & (state_next != uart_mon_pkg::st_idle))
		| abort;

	assign go_launch = (state == uart_mon_pkg::st_go_addr) & word.valid;
	assign arg_done  = word.valid & ((state == uart_mon_pkg::st_go_addr)
		| (state == uart_mon_pkg::st_wr_addr) | (state == uart_mon_pkg::st_rd_end)
		| (state == uart_mon_pkg::st_bp_addr));
	assign crlf_in   = arg_done | cr_c | abort;

endmodule

// File: src/monitor_ctrl_out.sv
// monitor output stage with control strobes, breakpoint and cpu start delay
`timescale 1ns/1ps

module monitor_ctrl_out (
	input  logic                             clk,
	input  logic                             rst_n,
	input  uart_mon_pkg::mon_state_e         state,
	input  uart_mon_pkg::mon_word_t          word,
	input  logic                             abort,
	input  logic                             go_launch,
	input  logic [uart_mon_pkg::word_w-1:0]  pc_data,
	input  logic                             cpu_run_state,
	output logic                             bp_hit,
	output logic                             cpu_start,
	output logic                             write_address_set,
	output logic                             write_data_en,
	output logic                             read_start_set,
	output logic                             read_end_set,
	output logic                             read_stop,
	output logic                             quit_cmd
);

	logic [uart_mon_pkg::word_w-1:2]          bp_addr; // word aligned
	logic                                     bp_en;
	logic [uart_mon_pkg::cpu_start_delay-1:0] start_sr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bp_addr <= '0;
			bp_en   <= 1'b0;
		end else if ((state == uart_mon_pkg::st_bp_addr) & word.valid) begin
			bp_addr <= word.data[uart_mon_pkg::word_w-1:2];
			bp_en   <= ~word.data[0]; // bit 0 set disables the break
		end
	end

	assign bp_hit = bp_en & cpu_run_state & (bp_addr == pc_data[uart_mon_pkg::word_w-1:2]);

	// go launch to cpu start
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			start_sr <= '0;
		else
			start_sr <= {start_sr[uart_mon_pkg::cpu_start_delay-2:0], go_launch};
	end

	assign cpu_start = start_sr[uart_mon_pkg::cpu_start_delay-1];

	assign write_address_set = (state == uart_mon_pkg::st_wr_addr) & word.valid;
	assign write_data_en     = (state == uart_mon_pkg::st_wr_data) & word.valid;
	assign read_start_set    = (state == uart_mon_pkg::st_rd_start) & word.valid;
	assign read_end_set      = (state == uart_mon_pkg::st_rd_end) & word.valid;
	assign read_stop         = (state == uart_mon_pkg::st_rd_dump) & abort;
	assign quit_cmd          = abort | bp_hit;

endmodule

// File: src/uart_char_decoder.sv
// uart character decoder that registers a received char and classifies it
`timescale 1ns/1ps

module uart_char_decoder (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [7:0]               rout,
	input  logic                     rout_en,
	output uart_mon_pkg::char_info_t char_info
);

	logic [7:0] char_q;    // last received char, held
	logic       char_en_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			char_q <= 8'd0;
		else if (rout_en)
			char_q <= rout;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			char_en_q <= 1'b0;
		else
			char_en_q <= rout_en; // one cycle behind the strobe
	end

	always_comb begin
		char_info.valid  = char_en_q;
		char_info.is_hex = 1'b0;
		char_info.nibble = '0;
		char_info.cmd    = uart_mon_pkg::cmd_none;
		if (char_q >= "0" && char_q <= "9") begin
			char_info.is_hex = 1'b1;
			char_info.nibble = char_q[3:0];
		end else if (char_q >= "a" && char_q <= "f") begin // lower case only
			char_info.is_hex = 1'b1;
			char_info.nibble = char_q[3:0] + 4'd9;
		end else begin
			case (char_q)
				uart_mon_pkg::chr_go:       char_info.cmd = uart_mon_pkg::cmd_go;
				uart_mon_pkg::chr_ctrl_c:   char_info.cmd = uart_mon_pkg::cmd_quit;
				uart_mon_pkg::chr_write:    char_info.cmd = uart_mon_pkg::cmd_write;
				uart_mon_pkg::chr_read:     char_info.cmd = uart_mon_pkg::cmd_read;
				uart_mon_pkg::chr_stop_set: char_info.cmd = uart_mon_pkg::cmd_stop_set;
				uart_mon_pkg::chr_cr:       char_info.cmd = uart_mon_pkg::cmd_cr;
				default:                    char_info.cmd = uart_mon_pkg::cmd_none;
			endcase
		end
	end

endmodule

// File: src/uart_mon_pkg.sv
// uart monitor package with shared widths, character codes and types
package uart_mon_pkg;

	// widths
	localparam int word_w          = 32;
	localparam int nibble_w        = 4;
	localparam int digits_per_word = 8;
	localparam int cpu_start_delay = 3; // go word valid to cpu_start

	// received character codes
	localparam logic [7:0] chr_ctrl_c   = 8'h03;
	localparam logic [7:0] chr_cr       = 8'h0d;
	localparam logic [7:0] chr_go       = "g";
	localparam logic [7:0] chr_write    = "w";
	localparam logic [7:0] chr_read     = "r";
	localparam logic [7:0] chr_stop_set = "s";

	// decoded command letters
	typedef enum logic [2:0] {
		cmd_none,
		cmd_go,
		cmd_quit,     // Ctrl-c
		cmd_write,
		cmd_read,
		cmd_stop_set,
		cmd_cr
	} mon_cmd_e;

	// command FSM states
	typedef enum logic [3:0] {
		st_idle,
		st_go_addr,
		st_go_run,    // cpu running until quit or break
		st_wr_addr,
		st_wr_data,
		st_rd_start,
		st_rd_end,
		st_rd_dump,
		st_bp_addr
	} mon_state_e;

	// one classified character, valid for a single cycle
	typedef struct packed {
		logic                valid;
		logic                is_hex;
		logic [nibble_w-1:0] nibble;
		mon_cmd_e            cmd;
	} char_info_t;

	// completed hex word
	typedef struct packed {
		logic              valid;
		logic [word_w-1:0] data;
	} mon_word_t;

endpackage

// File: src/uart_monitor_top.sv
// uart monitor top level joining decoder, collector, command FSM and outputs
`timescale 1ns/1ps

module uart_monitor_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [7:0]                      rout,
	input  logic                            rout_en,
	input  logic                            dump_running,
	input  logic [uart_mon_pkg::word_w-1:0] pc_data,
	input  logic                            cpu_run_state,
	output logic [uart_mon_pkg::word_w-1:0] uart_data,
	output logic                            cpu_start,
	output logic                            write_address_set,
	output logic                            write_data_en,
	output logic                            read_start_set,
	output logic                            read_end_set,
	output logic                            read_stop,
	output logic                            quit_cmd,
	output logic                            crlf_in
);

	uart_mon_pkg::char_info_t char_info;
	uart_mon_pkg::mon_word_t  word;
	uart_mon_pkg::mon_state_e state;
	logic                     collect;
	logic                     word_clear;
	logic                     abort;
	logic                     go_launch;
	logic                     bp_hit;

	// input side
	uart_char_decoder uart_char_decoder_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.rout      (rout),
		.rout_en   (rout_en),
		.char_info (char_info)
	);

	hex_word_collector hex_word_collector_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.char_info  (char_info),
		.collect    (collect),
		.word_clear (word_clear),
		.word       (word)
	);

	monitor_cmd_fsm monitor_cmd_fsm_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.char_info    (char_info),
		.word         (word),
		.dump_running (dump_running),
		.bp_hit       (bp_hit),
		.state        (state),
		.collect      (collect),
		.word_clear   (word_clear),
		.abort        (abort),
		.go_launch    (go_launch),
		.crlf_in      (crlf_in)
	);

	// output side
	monitor_ctrl_out monitor_ctrl_out_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.state             (state),
		.word              (word),
		.abort             (abort),
		.go_launch         (go_launch),
		.pc_data           (pc_data),
		.cpu_run_state     (cpu_run_state),
		.bp_hit            (bp_hit),
		.cpu_start         (cpu_start),
		.write_address_set (write_address_set),
		.write_data_en     (write_data_en),
		.read_start_set    (read_start_set),
		.read_end_set      (read_end_set),
		.read_stop         (read_stop),
		.quit_cmd          (quit_cmd)
	);

	assign uart_data = word.data; // last completed word

endmodule

// File: include/monitor_model.svh
// uart monitor reference model for the testbench, stepped once per clock edge
`ifndef MONITOR_MODEL_SVH
`define MONITOR_MODEL_SVH

typedef struct packed {
	logic [uart_mon_pkg::word_w-1:0] data;
	logic                            cpu_start;
	logic                            write_address_set;
	logic                            write_data_en;
	logic                            read_start_set;
	logic                            read_end_set;
	logic                            read_stop;
	logic                            quit_cmd;
	logic                            crlf_in;
} mon_outputs_t;

// model registers, all zero after reset
typedef struct packed {
	logic [7:0]                      chr;
	logic                            chr_v;      // strobe seen one cycle ago
	uart_mon_pkg::mon_state_e        state;
	logic [3:0]                      digits;
	logic [uart_mon_pkg::word_w-1:0] work;
	logic [uart_mon_pkg::word_w-1:0] data;
	logic                            word_v;
	logic [uart_mon_pkg::word_w-1:0] bp;
	logic                            bp_en;
	logic [3:0]                      start_wait; // cycles left until cpu_start
} model_regs_t;

function automatic logic is_hex_digit(input logic [7:0] c);
	return (c >= "0" && c <= "9") || (c >= "a" && c <= "f");
endfunction

function automatic logic [3:0] hex_value(input logic [7:0] c);
	logic [7:0] v;
	v = (c <= "9") ? c - "0" : c - "a" + 8'd10;
	return v[3:0];
endfunction

function automatic logic is_quit(input model_regs_t r);
	return r.chr_v && r.chr == uart_mon_pkg::chr_ctrl_c;
endfunction

// states that take hex digits
function automatic logic number_state(input uart_mon_pkg::mon_state_e s);
	return s != uart_mon_pkg::st_idle && s != uart_mon_pkg::st_go_run
		&& s != uart_mon_pkg::st_rd_dump;
endfunction

function automatic logic breakpoint_hit(input model_regs_t r, input logic [31:0] pc,
	input logic run);
	return r.bp_en && run && r.bp[31:2] == pc[31:2];
endfunction

function automatic mon_outputs_t expected_outputs(input model_regs_t r,
	input logic [31:0] pc, input logic run);
	mon_outputs_t o;
	o.data              = r.data;
	o.cpu_start         = r.start_wait == 4'd1;
	o.write_address_set = r.word_v && r.state == uart_mon_pkg::st_wr_addr;
	o.write_data_en     = r.word_v && r.state == uart_mon_pkg::st_wr_data;
	o.read_start_set    = r.word_v && r.state == uart_mon_pkg::st_rd_start;
	o.read_end_set      = r.word_v && r.state == uart_mon_pkg::st_rd_end;
	o.read_stop         = is_quit(r) && r.state == uart_mon_pkg::st_rd_dump;
	o.quit_cmd          = is_quit(r) || breakpoint_hit(r, pc, run);
	o.crlf_in           = is_quit(r) || (r.chr_v && r.chr == uart_mon_pkg::chr_cr)
		|| (r.word_v && (r.state == uart_mon_pkg::st_go_addr
		|| r.state == uart_mon_pkg::st_wr_addr || r.state == uart_mon_pkg::st_rd_end
		|| r.state == uart_mon_pkg::st_bp_addr));
	return o;
endfunction

function automatic model_regs_t next_model(input model_regs_t r, input logic [7:0] c,
	input logic c_en, input logic dump, input logic [31:0] pc, input logic run);
	model_regs_t n;
	n = r;
	if (r.word_v) begin
		case (r.state)
			uart_mon_pkg::st_go_addr:  n.state = uart_mon_pkg::st_go_run;
			uart_mon_pkg::st_wr_addr:  n.state = uart_mon_pkg::st_wr_data;
			uart_mon_pkg::st_rd_start: n.state = uart_mon_pkg::st_rd_end;
			uart_mon_pkg::st_rd_end:   n.state = uart_mon_pkg::st_rd_dump;
			uart_mon_pkg::st_bp_addr:  n.state = uart_mon_pkg::st_idle;
			default: ;
		endcase
	end
	if (r.state == uart_mon_pkg::st_go_run && breakpoint_hit(r, pc, run))
		n.state = uart_mon_pkg::st_idle;
	if (r.state == uart_mon_pkg::st_rd_dump && !dump)
		n.state = uart_mon_pkg::st_idle; // dump finished
	if (r.state == uart_mon_pkg::st_idle && r.chr_v) begin
		case (r.chr)
			uart_mon_pkg::chr_go:       n.state = uart_mon_pkg::st_go_addr;
			uart_mon_pkg::chr_write:    n.state = uart_mon_pkg::st_wr_addr;
			uart_mon_pkg::chr_read:     n.state = uart_mon_pkg::st_rd_start;
			uart_mon_pkg::chr_stop_set: n.state = uart_mon_pkg::st_bp_addr;
			default: ;
		endcase
	end
	if (is_quit(r))
		n.state = uart_mon_pkg::st_idle;
	n.word_v     = 1'b0;
	n.start_wait = (r.start_wait != 0) ? r.start_wait - 4'd1 : 4'd0;
	if (r.word_v && r.state == uart_mon_pkg::st_go_addr)
		n.start_wait = 4'(uart_mon_pkg::cpu_start_delay);
	if (r.word_v && r.state == uart_mon_pkg::st_bp_addr) begin
		n.bp    = r.data;
		n.bp_en = !r.data[0];
	end
	if ((r.state == uart_mon_pkg::st_idle && n.state != uart_mon_pkg::st_idle) || is_quit(r)) begin
		n.work   = '0;
		n.digits = '0;
	end else if (r.chr_v && is_hex_digit(r.chr) && number_state(r.state)) begin
		n.work   = {r.work[27:0], hex_value(r.chr)};
		n.digits = r.digits + 4'd1;
		if (n.digits == uart_mon_pkg::digits_per_word) begin
			n.data   = n.work;
			n.word_v = 1'b1;
			n.digits = '0;
		end
	end
	n.chr_v = c_en;
	if (c_en)
		n.chr = c;
	return n;
endfunction

`endif

// File: verif/uart_monitor_tb.sv
// uart monitor testbench with random commands checked against a cycle model
`timescale 1ns/1ps

module uart_monitor_tb;

	`include "monitor_model.svh"

	localparam int clk_period = 8;
	localparam int char_gap   = 4;   // cycles from one strobe to the next
	localparam int num_chars  = 140; // all tests together rounded up
	localparam int margin     = 200; // dump waits and pc sweeps

	logic                            clk;
	logic                            rst_n;
	logic [7:0]                      rout;
	logic                            rout_en;
	logic                            dump_running;
	logic [uart_mon_pkg::word_w-1:0] pc_data;
	logic                            cpu_run_state;
	logic [uart_mon_pkg::word_w-1:0] uart_data;
	logic                            cpu_start;
	logic                            write_address_set;
	logic                            write_data_en;
	logic                            read_start_set;
	logic                            read_end_set;
	logic                            read_stop;
	logic                            quit_cmd;
	logic                            crlf_in;
	mon_outputs_t                    actual;
	model_regs_t                     model;
	string                           test_name;
	integer                          seed = 42598;
	int                              start_count = 0;
	int                              quit_count = 0;

	uart_monitor_top uart_monitor_top_i (.*);

	assign actual = {uart_data, cpu_start, write_address_set, write_data_en, read_start_set,
		read_end_set, read_stop, quit_cmd, crlf_in};

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// model sees the inputs as they were before the edge
	always @(posedge clk) begin
		if (!rst_n)
			model = '0;
		else
			model = next_model(model, rout, rout_en, dump_running, pc_data, cpu_run_state);
	end

	// compared on falling edges once the model has taken its first reset edge
	initial begin
		@(posedge clk);
		forever begin
			@(negedge clk);
			check_value(test_name, expected_outputs(model, pc_data, cpu_run_state), actual);
			if (cpu_start)
				start_count++;
			if (quit_cmd)
				quit_count++;
		end
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] got);
		if (expected !== got) begin
			$display("ERR %s expected %h actual %h", name, expected, got);
			$display("ERRORS FOUND");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic send_char(input logic [7:0] c);
		@(posedge clk);
		rout    <= c;
		rout_en <= 1'b1;
		@(posedge clk);
		rout_en <= 1'b0;
		repeat (char_gap - 2) @(posedge clk);
	endtask

	// eight lower case digits with the most significant first
	task automatic send_word(input logic [31:0] value);
		logic [3:0] n;
		for (int i = 7; i >= 0; i--) begin
			n = value[i*4 +: 4];
			send_char((n < 10) ? "0" + n : "a" + n - 10);
		end
		@(negedge clk);
		check_value({test_name, " uart_data"}, value, uart_data);
	endtask

	// go from a random address and step the pc across the breakpoint
	task automatic sweep_to_break(input logic [31:0] target, input int hits);
		int quits_before;
		send_char(uart_mon_pkg::chr_go);
		send_word($random(seed));
		quits_before = quit_count;
		@(posedge clk);
		cpu_run_state <= 1'b1;
		pc_data       <= target - 32'd32;
		repeat (16) begin
			@(posedge clk);
			pc_data <= pc_data + 32'd4;
		end
		cpu_run_state <= 1'b0;
		@(posedge clk);
		check_value({test_name, " quit pulses"}, quits_before + hits, quit_count);
	endtask

	function automatic logic [7:0] filler_char(input int kind);
		int pick;
		pick = {$random(seed)} % 6;
		case (kind % 3)
			0:       return "A" + pick; // upper case hex is not a digit
			1:       return "0" + {$random(seed)} % 10;
			default: return "h" + pick; // h..m holds no command letter
		endcase
	endfunction

	initial begin
		logic [31:0] bp;
		logic [31:0] held;
		rst_n         = 1'b0;
		rout          = 8'd0;
		rout_en       = 1'b0;
		dump_running  = 1'b0;
		pc_data       = '0;
		cpu_run_state = 1'b0;
		test_name     = "reset";
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "write";
		send_char(uart_mon_pkg::chr_write);
		repeat (4) send_word($random(seed)); // address and three data words
		send_char(uart_mon_pkg::chr_ctrl_c);

		test_name = "read dump";
		@(posedge clk);
		dump_running <= 1'b1;
		send_char(uart_mon_pkg::chr_read);
		repeat (2) send_word($random(seed));
		repeat (8 + {$random(seed)} % 16) @(posedge clk); // dump length varies
		dump_running <= 1'b0;

		test_name = "read stop";
		@(posedge clk);
		dump_running <= 1'b1;
		send_char(uart_mon_pkg::chr_read);
		repeat (2) send_word($random(seed));
		send_char(uart_mon_pkg::chr_ctrl_c);
		dump_running <= 1'b0;

		test_name = "go";
		send_char(uart_mon_pkg::chr_go);
		send_word($random(seed));
		repeat (uart_mon_pkg::cpu_start_delay) @(posedge clk);
		check_value("go cpu_start pulses", 1, start_count);
		send_char(uart_mon_pkg::chr_ctrl_c);

		test_name = "break on";
		bp = $random(seed) & ~32'h3;
		send_char(uart_mon_pkg::chr_stop_set);
		send_word(bp);
		sweep_to_break(bp, 1);
		test_name = "break off";
		send_char(uart_mon_pkg::chr_stop_set);
		send_word(bp | 32'h1);
		sweep_to_break(bp, 0);
		send_char(uart_mon_pkg::chr_ctrl_c); // still running so quit by hand

		test_name = "filter";
		@(negedge clk);
		held = uart_data;
		for (int i = 0; i < 12; i++)
			send_char(filler_char(i));
		@(negedge clk);
		check_value("filter uart_data", held, uart_data);
		send_char(uart_mon_pkg::chr_cr);

		$display("NO ERRORS");
		$finish;
	end

	initial begin
		#((num_chars * char_gap + margin) * clk_period);
		$display("timeout, the tests did not finish in time");
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule
